//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert
TOP    := tb_irq_fetch
FLIST  := build.f
OBJDIR := obj_dir
PASS   := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FLIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q -F -- '$(PASS)'

clean:
	rm -rf $(OBJDIR)

//--- build.f
cpu_pkg.sv
irq_pkg.sv
irq_config_regs.sv
interrupt_controller.sv
pc_fetch_unit.sv
irq_fetch_top.sv
irq_fetch_assertions.sv
tb_clock_gen.sv
tb_irq_fetch.sv

//--- cpu_pkg.sv
package cpu_pkg;

	// Width of every PC value in the front end
	localparam int pc_width = 12;

	// PC loaded on reset
	localparam logic [pc_width-1:0] reset_pc = '0;

	// Major opcodes that fetch must recognize
	typedef enum logic [6:0] {
		op_alu    = 7'h33,	// Register ALU ops
		op_branch = 7'h63,	// Conditional branches
		op_jal    = 7'h6f,	// Jump and link
		op_system = 7'h73	// URET lives here
	} opcode_t;

endpackage

//--- interrupt_controller.sv
`timescale 1ns/1ps

module interrupt_controller (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          stall,
	input  logic                          irq_req,
	input  cpu_pkg::opcode_t              opcode,
	input  logic [cpu_pkg::pc_width-1:0]  pc_next,
	output logic                          sel_isr,
	output logic                          ret_isr,
	output logic                          isr_running,
	output logic                          isr_taken,
	output logic                          pc_flush,
	output logic                          pipe_flush,
	output logic [cpu_pkg::pc_width-1:0]  save_pc
);

	irq_pkg::isr_state_t state;
	logic [2:0]          drain_cnt;
	logic                armed;		// Request seen inactive since last entry
	logic                take_irq;
	logic                drain_done;
	logic                drain_active;
	logic                capture_pc;

	assign take_irq     = (state == irq_pkg::idle) && irq_req && armed;
	assign drain_done   = (drain_cnt == irq_pkg::drain_cycles);
	assign drain_active = (state == irq_pkg::enter_drain) || (state == irq_pkg::exit_drain);

	// PC holds during the entry drain, so pc_next only moves on a redirect
	assign capture_pc = take_irq || (state == irq_pkg::enter_drain);

	assign pc_flush   = drain_active && !stall;
	assign pipe_flush = drain_active && !stall;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state       <= irq_pkg::idle;
			drain_cnt   <= 3'd0;
			armed       <= 1'b1;
			sel_isr     <= 1'b0;
			ret_isr     <= 1'b0;
			isr_running <= 1'b0;
			isr_taken   <= 1'b0;
		end else begin
			isr_taken <= 1'b0;	// Single-cycle pulse
			if (!irq_req)
				armed <= 1'b1;
			case (state)
				irq_pkg::idle: begin
					if (take_irq) begin
						state     <= irq_pkg::enter_drain;
						drain_cnt <= 3'd1;
						armed     <= 1'b0;
					end
				end
				irq_pkg::enter_drain: begin
					if (drain_done) begin
						state       <= irq_pkg::in_isr;
						drain_cnt   <= 3'd0;
						isr_running <= 1'b1;
						sel_isr     <= 1'b1;
						isr_taken   <= 1'b1;
					end else if (!stall) begin
						drain_cnt <= drain_cnt + 3'd1;
					end
				end
				irq_pkg::in_isr: begin
					if (opcode == cpu_pkg::op_system) begin	// URET fetched
						state     <= irq_pkg::exit_drain;
						drain_cnt <= 3'd1;
						ret_isr   <= 1'b1;
						sel_isr   <= 1'b0;
					end
				end
				irq_pkg::exit_drain: begin
					if (drain_done) begin
						state       <= irq_pkg::idle;
						drain_cnt   <= 3'd0;
						isr_running <= 1'b0;
						ret_isr     <= 1'b0;
					end else if (!stall) begin
						drain_cnt <= drain_cnt + 3'd1;
					end
				end
				default: state <= irq_pkg::idle;
			endcase
		end
	end

	// Return address, tracked until the handler starts
	always_ff @(posedge clk) begin
		if (!nrst)
			save_pc <= '0;
		else if (capture_pc)
			save_pc <= pc_next;
	end

endmodule

//--- irq_config_regs.sv
`timescale 1ns/1ps

module irq_config_regs (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          int_n,
	input  logic                          cfg_wr,
	input  irq_pkg::cfg_addr_t            cfg_addr,
	input  logic [cpu_pkg::pc_width-1:0]  cfg_wdata,
	input  logic                          isr_taken,
	output logic                          irq_req,
	output logic [cpu_pkg::pc_width-1:0]  vector,
	output logic [cpu_pkg::pc_width-1:0]  cfg_rdata
);

	logic       enable;
	logic [7:0] irq_count;

	// Request line is active low at the pin
	assign irq_req = ~int_n & enable;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			vector    <= '0;
			enable    <= 1'b1;
			irq_count <= 8'd0;
		end else begin
			if (cfg_wr && cfg_addr == irq_pkg::cfg_vector)
				vector <= cfg_wdata;
			if (cfg_wr && cfg_addr == irq_pkg::cfg_enable)
				enable <= cfg_wdata[0];
			if (cfg_wr && cfg_addr == irq_pkg::cfg_count)
				irq_count <= 8'd0;	// Clear wins over a same-cycle increment
			else if (isr_taken)
				irq_count <= irq_count + 8'd1;	// Wraps at 255
		end
	end

	always_comb begin
		case (cfg_addr)
			irq_pkg::cfg_vector: cfg_rdata = vector;
			irq_pkg::cfg_enable: cfg_rdata = {{(cpu_pkg::pc_width-1){1'b0}}, enable};
			irq_pkg::cfg_count:  cfg_rdata = {{(cpu_pkg::pc_width-8){1'b0}}, irq_count};
			default:             cfg_rdata = '0;	// Unmapped address
		endcase
	end

endmodule

//--- irq_fetch_assertions.sv
`timescale 1ns/1ps

module irq_fetch_assertions (
	input logic                clk,
	input logic                nrst,
	input logic                stall,
	input logic                sel_isr,
	input logic                ret_isr,
	input logic                isr_running,
	input logic                isr_taken,
	input logic                pc_flush,
	input logic                pipe_flush,
	input irq_pkg::isr_state_t state
);

	a_sel_ret_exclusive: assert property (@(posedge clk) disable iff (!nrst)
		!(sel_isr && ret_isr)) else $error("sel_isr and ret_isr high together");

	a_flush_masked: assert property (@(posedge clk) disable iff (!nrst)
		stall |-> !pc_flush && !pipe_flush) else $error("Flush raised under stall");

	a_taken_pulse: assert property (@(posedge clk) disable iff (!nrst)
		isr_taken |=> !isr_taken) else $error("isr_taken longer than one cycle");

	// Handler flag only in the ISR or its exit drain
	a_running_state: assert property (@(posedge clk) disable iff (!nrst)
		isr_running |-> (state == irq_pkg::in_isr) || (state == irq_pkg::exit_drain))
		else $error("isr_running outside the handler states");

	a_reset_quiet: assert property (@(posedge clk)
		!nrst |=> !sel_isr && !ret_isr && !isr_running && !isr_taken && !pc_flush && !pipe_flush)
		else $error("Controller output high during reset");

endmodule

//--- irq_fetch_testdata.mem
// Record columns: command, selector, argument, expected value (all hex)
// Commands: 1 cfg write, 2 run, 3 int_n, 4 opcode, 5 redirect, 6 stall, 7 wait, 8 check, 9 end
8 0 000 000  8 3 000 000  8 4 000 000  8 5 000 000  2 1 00A 000  8 0 000 028  // Reset
8 2 002 000  9 0 001 000
1 0 400 000  8 2 000 400  3 1 000 000  7 1 000 400  8 6 000 000  3 0 000 000  // Entry
9 0 002 000
4 0 073 000  7 0 000 000  2 1 003 000  8 7 000 000  9 0 003 000  // Return
3 1 000 000  5 0 1A0 000  7 1 000 400  8 1 000 1A0  8 6 000 000  3 0 000 000  // Redirect
4 0 073 000  7 0 000 000  8 0 000 1A0  2 1 002 000  8 0 000 1A8  9 0 004 000
1 1 000 000  8 2 001 000  3 1 000 000  2 1 014 000  8 3 000 000  6 1 000 000  // Masked
2 1 00A 000  8 7 000 000  8 4 000 000  6 0 000 000  3 0 000 000  1 1 001 000
9 0 005 000
8 2 002 002  1 2 000 000  8 2 002 000  9 0 006 000  0 0 000 000  // Count

//--- irq_fetch_top.sv
`timescale 1ns/1ps

module irq_fetch_top (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          int_n,
	input  logic                          stall,
	input  logic [6:0]                    opcode,
	input  logic                          redirect,
	input  logic [cpu_pkg::pc_width-1:0]  redirect_target,
	input  logic                          cfg_wr,
	input  logic [1:0]                    cfg_addr,
	input  logic [cpu_pkg::pc_width-1:0]  cfg_wdata,
	output logic [cpu_pkg::pc_width-1:0]  pc,
	output logic [cpu_pkg::pc_width-1:0]  cfg_rdata,
	output logic                          isr_running,
	output logic                          pc_flush,
	output logic                          pipe_flush,
	output logic [cpu_pkg::pc_width-1:0]  save_pc
);

	logic                         irq_req;
	logic                         isr_taken;
	logic                         sel_isr;
	logic                         ret_isr;
	logic [cpu_pkg::pc_width-1:0] vector;
	logic [cpu_pkg::pc_width-1:0] pc_next;

	irq_config_regs i_cfg (
		.clk       (clk),
		.nrst      (nrst),
		.int_n     (int_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (irq_pkg::cfg_addr_t'(cfg_addr)),
		.cfg_wdata (cfg_wdata),
		.isr_taken (isr_taken),
		.irq_req   (irq_req),
		.vector    (vector),
		.cfg_rdata (cfg_rdata)
	);

	interrupt_controller i_ctrl (
		.clk         (clk),
		.nrst        (nrst),
		.stall       (stall),
		.irq_req     (irq_req),
		.opcode      (cpu_pkg::opcode_t'(opcode)),
		.pc_next     (pc_next),
		.sel_isr     (sel_isr),
		.ret_isr     (ret_isr),
		.isr_running (isr_running),
		.isr_taken   (isr_taken),
		.pc_flush    (pc_flush),
		.pipe_flush  (pipe_flush),
		.save_pc     (save_pc)
	);

	pc_fetch_unit i_fetch (
		.clk             (clk),
		.nrst            (nrst),
		.stall           (stall),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.vector          (vector),
		.save_pc         (save_pc),
		.sel_isr         (sel_isr),
		.ret_isr         (ret_isr),
		.pc_flush        (pc_flush),
		.pc              (pc),
		.pc_next         (pc_next)
	);

endmodule

//--- irq_pkg.sv
package irq_pkg;

	// Counter value that ends an entry or exit drain
	localparam logic [2:0] drain_cycles = 3'd5;

	typedef enum logic [1:0] {
		idle        = 2'd0,	// Normal fetch
		enter_drain = 2'd1,	// Emptying pipe before ISR
		in_isr      = 2'd2,	// Handler running
		exit_drain  = 2'd3	// Emptying pipe after URET
	} isr_state_t;

	// Config register map
	typedef enum logic [1:0] {
		cfg_vector = 2'd0,	// ISR entry address
		cfg_enable = 2'd1,	// Bit 0 enables the request line
		cfg_count  = 2'd2	// Interrupts taken, write clears
	} cfg_addr_t;

endpackage

//--- pc_fetch_unit.sv
`timescale 1ns/1ps

module pc_fetch_unit (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          stall,
	input  logic                          redirect,
	input  logic [cpu_pkg::pc_width-1:0]  redirect_target,
	input  logic [cpu_pkg::pc_width-1:0]  vector,
	input  logic [cpu_pkg::pc_width-1:0]  save_pc,
	input  logic                          sel_isr,
	input  logic                          ret_isr,
	input  logic                          pc_flush,
	output logic [cpu_pkg::pc_width-1:0]  pc,
	output logic [cpu_pkg::pc_width-1:0]  pc_next
);

	localparam logic [cpu_pkg::pc_width-1:0] pc_step = 4;	// One 32-bit instruction

	logic sel_isr_q;
	logic isr_entry;

	// Vector jump happens once, on the rising edge of sel_isr
	assign isr_entry = sel_isr && !sel_isr_q;

	always_ff @(posedge clk) begin
		if (!nrst)
			sel_isr_q <= 1'b0;
		else
			sel_isr_q <= sel_isr;
	end

	always_comb begin
		if (isr_entry)
			pc_next = vector;
		else if (ret_isr)
			pc_next = save_pc;	// Return target held through the exit drain
		else if (redirect)
			pc_next = redirect_target;
		else if (stall || pc_flush)
			pc_next = pc;
		else
			pc_next = pc + pc_step;
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			pc <= cpu_pkg::reset_pc;
		else
			pc <= pc_next;
	end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic nrst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial begin
		nrst <= 1'b0;
		repeat (16) @(posedge clk);
		nrst <= 1'b1;	// Seen by the DUT from the 17th edge
	end

endmodule

//--- tb_irq_fetch.sv
`timescale 1ns/1ps

module tb_irq_fetch;

	localparam int max_records = 64;
	localparam int wait_limit  = 50;	// Cycles allowed for any wait

	logic                         clk;
	logic                         nrst;
	logic                         int_n;
	logic                         stall;
	logic [6:0]                   opcode;
	logic                         redirect;
	logic [cpu_pkg::pc_width-1:0] redirect_target;
	logic                         cfg_wr;
	logic [1:0]                   cfg_addr;
	logic [cpu_pkg::pc_width-1:0] cfg_wdata;
	logic [cpu_pkg::pc_width-1:0] pc;
	logic [cpu_pkg::pc_width-1:0] cfg_rdata;
	logic                         isr_running;
	logic                         pc_flush;
	logic                         pipe_flush;
	logic [cpu_pkg::pc_width-1:0] save_pc;

	logic [cpu_pkg::pc_width-1:0] words [0:4*max_records-1];	// Four words per record
	logic [cpu_pkg::pc_width-1:0] seq_pc;	// Where free-running fetch should be
	logic [cpu_pkg::pc_width-1:0] exp_save;	// Return address the controller should hold
	int                           test_errors;
	int                           errors;
	int                           tests_run;
	int                           tests_passed;

	tb_clock_gen i_clk (.*);

	irq_fetch_top i_dut (.*);

	bind interrupt_controller irq_fetch_assertions i_assert (
		.clk         (clk),
		.nrst        (nrst),
		.stall       (stall),
		.sel_isr     (sel_isr),
		.ret_isr     (ret_isr),
		.isr_running (isr_running),
		.isr_taken   (isr_taken),
		.pc_flush    (pc_flush),
		.pipe_flush  (pipe_flush),
		.state       (state)
	);

	function automatic logic [cpu_pkg::pc_width-1:0] widen(input logic flag);
		return {{(cpu_pkg::pc_width-1){1'b0}}, flag};
	endfunction

	// One clock edge; fetch steps by 4 unless this edge sees stall
	task automatic cycle();
		@(posedge clk);
		if (!stall)
			seq_pc = seq_pc + 12'd4;
	endtask

	task automatic check_value(input string name, input logic [cpu_pkg::pc_width-1:0] want,
			input logic [cpu_pkg::pc_width-1:0] got);
		if (got !== want) begin
			$display("FAILED %s: expected 0x%h, got 0x%h", name, want, got);
			test_errors++;
		end
	endtask

	task automatic wait_running(input logic level, output bit reached);
		reached = 1'b0;
		for (int n = 0; n < wait_limit && !reached; n++) begin
			@(posedge clk);
			@(negedge clk);
			if (isr_running === level) begin
				reached = 1'b1;
			end else begin
				check_value("pc_flush", widen(!stall), widen(pc_flush));	// Drain still running
				check_value("pipe_flush", widen(!stall), widen(pipe_flush));
			end
		end
	endtask

	initial begin
		logic [7:0]                   base;
		logic [3:0]                   cmd;
		logic [3:0]                   sel;
		logic [cpu_pkg::pc_width-1:0] arg;
		logic [cpu_pkg::pc_width-1:0] want;
		bit                           reached;
		bit                           finished;
		int_n           <= 1'b1;
		stall           <= 1'b0;
		opcode          <= cpu_pkg::op_alu;
		redirect        <= 1'b0;
		redirect_target <= '0;
		cfg_wr          <= 1'b0;
		cfg_addr        <= 2'd0;
		cfg_wdata       <= '0;
		seq_pc       = cpu_pkg::reset_pc;
		exp_save     = '0;
		test_errors  = 0;
		errors       = 0;
		tests_run    = 0;
		tests_passed = 0;
		finished     = 1'b0;
		$readmemh("irq_fetch_testdata.mem", words);
		for (int n = 0; n < 100 && nrst !== 1'b1; n++)
			@(negedge clk);
		if (nrst !== 1'b1) begin
			$display("Reset was never released");
			test_errors++;
			finished = 1'b1;
		end
		for (int idx = 0; idx < max_records && !finished; idx++) begin
			base = 8'(idx * 4);
			cmd  = words[base][3:0];
			sel  = words[base + 8'd1][3:0];
			arg  = words[base + 8'd2];
			want = words[base + 8'd3];
			case (cmd)
				4'h0: finished = 1'b1;
				4'h1: begin
					cycle();
					cfg_wr    <= 1'b1;
					cfg_addr  <= sel[1:0];
					cfg_wdata <= arg;
					cycle();
					cfg_wr <= 1'b0;
					@(negedge clk);
				end
				4'h2: begin
					repeat (arg) begin
						cycle();
						@(negedge clk);
						if (sel[0])
							check_value("pc", seq_pc, pc);	// Plain sequential fetch expected
						if (sel[0] && isr_running) begin
							$display("isr_running went high while no entry was expected");
							test_errors++;
						end
					end
				end
				4'h3: begin
					cycle();
					int_n <= ~sel[0];
					if (sel[0])
						exp_save = seq_pc + 12'd4;	// PC loaded on the request edge
					@(negedge clk);
				end
				4'h4: begin
					cycle();
					opcode <= arg[6:0];
					cycle();
					opcode <= cpu_pkg::op_alu;
					@(negedge clk);
				end
				4'h5: begin
					cycle();
					redirect        <= 1'b1;
					redirect_target <= arg;
					cycle();
					redirect <= 1'b0;
					seq_pc   = arg;
					exp_save = arg;	// Recaptured while draining
					@(negedge clk);
				end
				4'h6: begin
					cycle();
					stall <= sel[0];
					@(negedge clk);
				end
				4'h7: begin
					wait_running(sel[0], reached);
					if (!reached) begin
						$display("Timed out after %0d cycles waiting for isr_running to become %0d",
							wait_limit, sel[0]);
						test_errors++;
						finished = 1'b1;
					end else if (sel[0]) begin
						@(posedge clk);
						@(negedge clk);
						check_value("pc", want, pc);	// Vector one edge after entry
					end else begin
						check_value("pc", exp_save, pc);
						seq_pc = exp_save;
					end
				end
				4'h8: begin
					case (sel)
						4'h0: check_value("pc", want, pc);
						4'h1: check_value("save_pc", want, save_pc);
						4'h2: begin
							cycle();
							cfg_addr <= arg[1:0];
							@(negedge clk);
							check_value("cfg_rdata", want, cfg_rdata);
						end
						4'h3: check_value("isr_running", want, widen(isr_running));
						4'h4: check_value("pc_flush", want, widen(pc_flush));
						4'h5: check_value("pipe_flush", want, widen(pipe_flush));
						4'h6: check_value("save_pc", exp_save, save_pc);
						4'h7: check_value("pc", seq_pc, pc);
						default: begin
							$display("Record %0d asks for an unknown check %0d", idx, sel);
							test_errors++;
						end
					endcase
				end
				4'h9: begin
					tests_run++;
					if (test_errors == 0) begin
						tests_passed++;
						$display("Test %0d passed", arg);
					end else begin
						$display("Test %0d failed with %0d errors", arg, test_errors);
					end
					errors += test_errors;
					test_errors = 0;
				end
				default: begin
					$display("Record %0d holds an unknown command code", idx);
					test_errors++;
					finished = 1'b1;
				end
			endcase
		end
		errors += test_errors;
		$display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
		if (errors == 0 && tests_run > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
